// File: common/mem_msg_pkg.sv
`default_nettype none

package mem_msg_pkg;

  // processor side
  localparam int word_bits = 32;
  localparam int addr_bits = 32;

  // memory side moves whole lines
  localparam int line_bits = 512;
  localparam int line_bytes = line_bits / 8;

  // memory port address counts lines, not bytes
  localparam int line_addr_bits = addr_bits - $clog2(line_bytes);

  typedef enum logic {
    mem_read  = 1'b0,
    mem_write = 1'b1
  } mem_op_e;

  // one registered processor request, 65 bits
  typedef struct packed {
    mem_op_e               op;
    logic [addr_bits-1:0]  addr;  // byte address
    logic [word_bits-1:0]  data;  // store data, ignored on reads
  } cpu_req_t;

endpackage

`default_nettype wire

// File: common/cache_pkg.sv
`default_nettype none

package cache_pkg;

  // 16 words of 32 bits per line
  localparam int words_per_line = mem_msg_pkg::line_bits / mem_msg_pkg::word_bits;
  localparam int word_off_bits = $clog2(words_per_line);
  localparam int byte_off_bits = $clog2(mem_msg_pkg::word_bits / 8);

  // low address bits inside one line
  localparam int line_off_bits = word_off_bits + byte_off_bits;

  typedef enum logic [2:0] {
    s_idle,
    s_lookup,
    s_writeback,    // dirty victim sent, waiting for ack
    s_refill_req,
    s_refill_wait,
    s_flush_scan,
    s_flush_wb
  } ctrl_state_e;

endpackage

`default_nettype wire

// File: common/cache_array_if.sv
`default_nettype none

interface cache_array_if #(
  parameter int num_lines = 32
);

  localparam int index_bits = $clog2(num_lines);
  localparam int tag_bits = mem_msg_pkg::addr_bits - cache_pkg::line_off_bits - index_bits;

  // driven by the controller
  logic [index_bits-1:0]                 index;
  logic [tag_bits-1:0]                   tag;
  logic [cache_pkg::word_off_bits-1:0]   word_sel;
  logic                                  wr_word;     // store hit
  logic                                  wr_line;     // refill
  logic [mem_msg_pkg::word_bits-1:0]     wdata_word;
  logic [mem_msg_pkg::line_bits-1:0]     wdata_line;
  logic                                  set_dirty;
  logic                                  clr_dirty;
  logic                                  invalidate_all;

  // lookup results, combinational on index
  logic                                  hit;
  logic                                  dirty;
  logic [tag_bits-1:0]                   victim_tag;
  logic [mem_msg_pkg::line_bits-1:0]     rline;
  logic [mem_msg_pkg::word_bits-1:0]     rword;

  modport ctrl (
    output index, tag, word_sel, wr_word, wr_line, wdata_word, wdata_line,
    output set_dirty, clr_dirty, invalidate_all,
    input  hit, dirty, victim_tag, rline, rword
  );

  modport tags (
    input  index, tag, wr_line, set_dirty, clr_dirty, invalidate_all,
    output hit, dirty, victim_tag
  );

  modport data (
    input  index, word_sel, wr_word, wr_line, wdata_word, wdata_line,
    output rline, rword
  );

endinterface

`default_nettype wire

// File: cache/cache_tag_array.sv
`default_nettype none

module cache_tag_array #(
  parameter int num_lines = 32
) (
  input  wire logic       clk,
  input  wire logic       reset,
  cache_array_if.tags     arr
);

  localparam int index_bits = $clog2(num_lines);
  localparam int tag_bits = mem_msg_pkg::addr_bits - cache_pkg::line_off_bits - index_bits;

  logic [tag_bits-1:0]  tags [num_lines];
  logic [num_lines-1:0] valid_bits;
  logic [num_lines-1:0] dirty_bits;

  // tag storage behaves like an sram
  always_ff @(posedge clk) begin
    if (arr.wr_line) begin
      tags[arr.index] <= arr.tag;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_bits <= '0;
      dirty_bits <= '0;
    end else if (arr.invalidate_all) begin
      valid_bits <= '0;  // end of flush
      dirty_bits <= '0;
    end else begin
      if (arr.wr_line) begin
        valid_bits[arr.index] <= 1'b1;
        dirty_bits[arr.index] <= 1'b0;  // fresh line from memory
      end
      if (arr.set_dirty) begin
        dirty_bits[arr.index] <= 1'b1;
      end
      if (arr.clr_dirty) begin
        dirty_bits[arr.index] <= 1'b0;  // written back during flush
      end
    end
  end

  assign arr.hit = valid_bits[arr.index] && (tags[arr.index] == arr.tag);
  assign arr.dirty = valid_bits[arr.index] && dirty_bits[arr.index];
  assign arr.victim_tag = tags[arr.index];  // tag of whatever sits at index

  // a store may only land on a line that the controller refilled first
  a_dirty_needs_valid : assert property (
    @(posedge clk) disable iff (reset)
    arr.set_dirty |-> valid_bits[arr.index]
  ) else $error("set_dirty on invalid line %0d", arr.index);

endmodule

`default_nettype wire

// File: cache/cache_data_array.sv
`default_nettype none

module cache_data_array #(
  parameter int num_lines = 32
) (
  input  wire logic       clk,
  cache_array_if.data     arr
);

  localparam int word_bits = mem_msg_pkg::word_bits;
  localparam int words = cache_pkg::words_per_line;

  logic [mem_msg_pkg::line_bits-1:0] lines [num_lines];
  logic [words-1:0]                  word_en;

  // one-hot enable for the addressed word
  always_comb begin
    for (int w = 0; w < words; w++) begin
      word_en[w] = (int'(arr.word_sel) == w);
    end
  end

  always_ff @(posedge clk) begin
    if (arr.wr_line) begin
      lines[arr.index] <= arr.wdata_line;  // refill, whole line
    end else if (arr.wr_word) begin
      for (int w = 0; w < words; w++) begin
        if (word_en[w]) begin
          lines[arr.index][w*word_bits +: word_bits] <= arr.wdata_word;
        end
      end
    end
  end

  // combinational read, like the sram model
  assign arr.rline = lines[arr.index];
  assign arr.rword = arr.rline[int'(arr.word_sel)*word_bits +: word_bits];

  // refill and store hit come from different controller states
  a_one_write : assert property (
    @(posedge clk) !(arr.wr_line && arr.wr_word)
  ) else $error("line and word write in the same cycle");

endmodule

`default_nettype wire

// File: cache/cache_ctrl.sv
`default_nettype none

module cache_ctrl #(
  parameter int num_lines = 32
) (
  input  wire logic                                   clk,
  input  wire logic                                   reset,
  input  wire logic                                   req_en,
  input  wire mem_msg_pkg::cpu_req_t                  req,
  input  wire logic                                   flush,
  input  wire logic                                   mem_resp_en,
  input  wire logic [mem_msg_pkg::line_bits-1:0]      mem_resp_line,
  output logic                                        busy,
  output logic                                        resp_en,
  output logic [mem_msg_pkg::word_bits-1:0]           resp_data,
  output logic                                        flush_done,
  output logic                                        mem_req_en,
  output logic                                        mem_req_write,
  output logic [mem_msg_pkg::line_addr_bits-1:0]      mem_req_addr,
  cache_array_if.ctrl                                 arr
);

  localparam int index_bits = $clog2(num_lines);
  localparam int tag_bits = mem_msg_pkg::addr_bits - cache_pkg::line_off_bits - index_bits;

  cache_pkg::ctrl_state_e               state;
  mem_msg_pkg::cpu_req_t                req_q;
  logic [index_bits-1:0]                flush_idx;
  logic [tag_bits-1:0]                  req_tag;
  logic [index_bits-1:0]                req_index;
  logic [cache_pkg::word_off_bits-1:0]  req_word;
  logic                                 walking;
  logic                                 flush_last;

  // address split of the registered request
  assign req_tag = req_q.addr[mem_msg_pkg::addr_bits-1 -: tag_bits];
  assign req_index = req_q.addr[cache_pkg::line_off_bits +: index_bits];
  assign req_word = req_q.addr[cache_pkg::byte_off_bits +: cache_pkg::word_off_bits];

  assign walking = (state == cache_pkg::s_flush_scan) || (state == cache_pkg::s_flush_wb);
  assign flush_last = (flush_idx == index_bits'(num_lines - 1));

  // array strobes
  assign arr.index = walking ? flush_idx : req_index;  // flush walks its own counter
  assign arr.tag = req_tag;
  assign arr.word_sel = req_word;
  assign arr.wdata_word = req_q.data;
  assign arr.wdata_line = mem_resp_line;  // refill straight from memory
  assign arr.wr_word = (state == cache_pkg::s_lookup) && arr.hit &&
                       (req_q.op == mem_msg_pkg::mem_write);
  assign arr.set_dirty = arr.wr_word;
  assign arr.wr_line = (state == cache_pkg::s_refill_wait) && mem_resp_en;
  assign arr.clr_dirty = (state == cache_pkg::s_flush_wb) && mem_resp_en;
  assign arr.invalidate_all = (state == cache_pkg::s_flush_scan) && !arr.dirty && flush_last;

  // held through the response and flush_done cycles
  assign busy = (state != cache_pkg::s_idle) || resp_en || flush_done;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= cache_pkg::s_idle;
      resp_en <= 1'b0;
      flush_done <= 1'b0;
      mem_req_en <= 1'b0;
      mem_req_write <= 1'b0;
      flush_idx <= '0;
    end else begin
      resp_en <= 1'b0;  // pulses by default
      flush_done <= 1'b0;
      mem_req_en <= 1'b0;
      case (state)
        cache_pkg::s_idle: begin
          if (req_en) begin
            state <= cache_pkg::s_lookup;
          end else if (flush) begin
            flush_idx <= '0;
            state <= cache_pkg::s_flush_scan;
          end
        end
        cache_pkg::s_lookup: begin
          if (arr.hit) begin
            resp_en <= 1'b1;
            state <= cache_pkg::s_idle;
          end else if (arr.dirty) begin
            mem_req_en <= 1'b1;  // evict victim first
            mem_req_write <= 1'b1;
            state <= cache_pkg::s_writeback;
          end else begin
            state <= cache_pkg::s_refill_req;  // clean victim, just drop it
          end
        end
        cache_pkg::s_writeback: begin
          if (mem_resp_en) begin
            state <= cache_pkg::s_refill_req;
          end
        end
        cache_pkg::s_refill_req: begin
          mem_req_en <= 1'b1;
          mem_req_write <= 1'b0;
          state <= cache_pkg::s_refill_wait;
        end
        cache_pkg::s_refill_wait: begin
          if (mem_resp_en) begin
            state <= cache_pkg::s_lookup;  // retry, now hits
          end
        end
        cache_pkg::s_flush_scan: begin
          if (arr.dirty) begin
            mem_req_en <= 1'b1;
            mem_req_write <= 1'b1;
            state <= cache_pkg::s_flush_wb;
          end else if (flush_last) begin
            flush_done <= 1'b1;
            state <= cache_pkg::s_idle;
          end else begin
            flush_idx <= flush_idx + 1'b1;
          end
        end
        cache_pkg::s_flush_wb: begin
          // line is clean after the ack, scan sees it again and moves on
          if (mem_resp_en) begin
            state <= cache_pkg::s_flush_scan;
          end
        end
        default: state <= cache_pkg::s_idle;
      endcase
    end
  end

  // payload registers
  always_ff @(posedge clk) begin
    if ((state == cache_pkg::s_idle) && req_en) begin
      req_q <= req;
    end
    if ((state == cache_pkg::s_lookup) && arr.hit) begin
      resp_data <= (req_q.op == mem_msg_pkg::mem_read) ? arr.rword : '0;
    end
    if ((state == cache_pkg::s_lookup) || (state == cache_pkg::s_flush_scan)) begin
      mem_req_addr <= {arr.victim_tag, arr.index};  // write-back target
    end else if (state == cache_pkg::s_refill_req) begin
      mem_req_addr <= {req_tag, req_index};
    end
  end

  a_no_req_while_busy : assert property (
    @(posedge clk) disable iff (reset)
    busy |-> !(req_en || flush)
  ) else $error("request or flush while busy");

  // memory sees one strobe per transfer
  a_mem_req_pulse : assert property (
    @(posedge clk) disable iff (reset)
    mem_req_en |=> !mem_req_en
  ) else $error("mem_req_en held longer than one cycle");

endmodule

`default_nettype wire

// File: hw/cache_top.sv
`default_nettype none

module cache_top #(
  parameter int num_lines = 32
) (
  input  wire logic                                  clk,
  input  wire logic                                  reset,
  // processor
  input  wire logic                                  req_en,
  input  wire logic                                  req_write,
  input  wire logic [mem_msg_pkg::addr_bits-1:0]     req_addr,
  input  wire logic [mem_msg_pkg::word_bits-1:0]     req_data,
  output logic                                       busy,
  output logic                                       resp_en,
  output logic [mem_msg_pkg::word_bits-1:0]          resp_data,
  // flush
  input  wire logic                                  flush,
  output logic                                       flush_done,
  // memory
  output logic                                       mem_req_en,
  output logic                                       mem_req_write,
  output logic [mem_msg_pkg::line_addr_bits-1:0]     mem_req_addr,
  output logic [mem_msg_pkg::line_bits-1:0]          mem_req_line,
  input  wire logic                                  mem_resp_en,
  input  wire logic [mem_msg_pkg::line_bits-1:0]     mem_resp_line
);

  mem_msg_pkg::cpu_req_t req;

  cache_array_if #(.num_lines(num_lines)) arr ();

  assign req.op = req_write ? mem_msg_pkg::mem_write : mem_msg_pkg::mem_read;
  assign req.addr = req_addr;
  assign req.data = req_data;

  assign mem_req_line = arr.rline;  // victim line, index held during write-back

  cache_ctrl #(.num_lines(num_lines)) u_ctrl (
    .clk           (clk),
    .reset         (reset),
    .req_en        (req_en),
    .req           (req),
    .flush         (flush),
    .mem_resp_en   (mem_resp_en),
    .mem_resp_line (mem_resp_line),
    .busy          (busy),
    .resp_en       (resp_en),
    .resp_data     (resp_data),
    .flush_done    (flush_done),
    .mem_req_en    (mem_req_en),
    .mem_req_write (mem_req_write),
    .mem_req_addr  (mem_req_addr),
    .arr           (arr.ctrl)
  );

  cache_tag_array #(.num_lines(num_lines)) u_tags (
    .clk   (clk),
    .reset (reset),
    .arr   (arr.tags)
  );

  cache_data_array #(.num_lines(num_lines)) u_data (
    .clk (clk),
    .arr (arr.data)
  );

endmodule

`default_nettype wire

// File: dv/mem_model.sv
`default_nettype none

module mem_model (
  input  wire logic                                  clk,
  input  wire logic                                  reset,
  input  wire logic                                  req_en,
  input  wire logic                                  req_write,
  input  wire logic [mem_msg_pkg::line_addr_bits-1:0] req_addr,
  input  wire logic [mem_msg_pkg::line_bits-1:0]     req_line,
  output logic                                       resp_en,
  output logic [mem_msg_pkg::line_bits-1:0]          resp_line,
  output int                                         wb_count
);

  logic [mem_msg_pkg::line_bits-1:0] lines [logic [mem_msg_pkg::line_addr_bits-1:0]];
  logic [mem_msg_pkg::line_addr_bits-1:0] pend_addr;
  logic                                   pend_write;
  logic                                   pending;
  int                                     delay;
  int                                     seed = 96535;

  // background contents, a function of the full byte address
  function automatic logic [31:0] fill_word(input logic [31:0] a);
    return {a[9:2], a[31:8]} ^ 32'h5ca1_ab1e;
  endfunction

  function automatic logic [mem_msg_pkg::line_bits-1:0] read_line(
    input logic [mem_msg_pkg::line_addr_bits-1:0] la
  );
    logic [mem_msg_pkg::line_bits-1:0] line;
    int w;
    if (lines.exists(la)) begin
      return lines[la];
    end
    for (w = 0; w < 16; w++) begin
      line[w*32 +: 32] = fill_word({la, 4'(w), 2'b00});
    end
    return line;
  endfunction

  initial begin
    resp_en = 1'b0;
    resp_line = '0;
    wb_count = 0;
    pending = 1'b0;
    pend_write = 1'b0;
    pend_addr = '0;
    delay = 0;
    forever begin
      @(posedge clk);
      #1;
      resp_en = 1'b0;
      if (reset) begin
        pending = 1'b0;
      end else begin
        if (pending) begin
          delay--;
          if (delay == 0) begin
            resp_en = 1'b1;  // one-cycle answer
            pending = 1'b0;
            if (!pend_write) begin
              resp_line = read_line(pend_addr);
            end
          end
        end
        if (req_en) begin
          pending = 1'b1;
          pend_write = req_write;
          pend_addr = req_addr;
          delay = 1 + int'($unsigned($random(seed)) % 32'd8);  // 1 to 8 cycles
          if (req_write) begin
            lines[req_addr] = req_line;
            wb_count++;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: dv/cache_tb.sv
`default_nettype none

module cache_tb;

  localparam int num_lines = 32;
  localparam int tag_bits = 21;  // 32 - 6 offset - 5 index

  logic         clk;
  logic         reset;
  logic         req_en;
  logic         req_write;
  logic [31:0]  req_addr;
  logic [31:0]  req_data;
  logic         busy;
  logic         resp_en;
  logic [31:0]  resp_data;
  logic         flush;
  logic         flush_done;
  logic         mem_req_en;
  logic         mem_req_write;
  logic [25:0]  mem_req_addr;
  logic [511:0] mem_req_line;
  logic         mem_resp_en;
  logic [511:0] mem_resp_line;
  int           wb_count;

  // reference state
  logic [tag_bits-1:0]  ref_tag [num_lines];
  logic [num_lines-1:0] ref_valid;
  logic [num_lines-1:0] ref_dirty;
  logic [31:0]          ref_mem [logic [29:0]];
  logic [26:0]          mem_log [$];  // {write, line address}
  logic [511:0]         wb_line;
  logic [31:0]          stored_addr [$];
  int                   seed = 96535;
  int                   checks;
  int                   errors;
  logic                 timed_out;

  cache_top #(.num_lines(num_lines)) u_cache_top (
    .clk           (clk),
    .reset         (reset),
    .req_en        (req_en),
    .req_write     (req_write),
    .req_addr      (req_addr),
    .req_data      (req_data),
    .busy          (busy),
    .resp_en       (resp_en),
    .resp_data     (resp_data),
    .flush         (flush),
    .flush_done    (flush_done),
    .mem_req_en    (mem_req_en),
    .mem_req_write (mem_req_write),
    .mem_req_addr  (mem_req_addr),
    .mem_req_line  (mem_req_line),
    .mem_resp_en   (mem_resp_en),
    .mem_resp_line (mem_resp_line)
  );

  mem_model u_mem (
    .clk       (clk),
    .reset     (reset),
    .req_en    (mem_req_en),
    .req_write (mem_req_write),
    .req_addr  (mem_req_addr),
    .req_line  (mem_req_line),
    .resp_en   (mem_resp_en),
    .resp_line (mem_resp_line),
    .wb_count  (wb_count)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // log memory traffic of the current access
  always @(posedge clk) begin
    #1;
    if (mem_req_en) begin
      mem_log.push_back({mem_req_write, mem_req_addr});
      if (mem_req_write) begin
        wb_line = mem_req_line;
      end
    end
  end

  a_resp_pulse : assert property (@(posedge clk) disable iff (reset) resp_en |=> !resp_en)
    else begin
      errors++;
      $display("resp_en stayed high for more than one cycle");
    end

  a_flush_done_pulse : assert property (
    @(posedge clk) disable iff (reset) flush_done |=> !flush_done
  ) else begin
    errors++;
    $display("flush_done stayed high for more than one cycle");
  end

  function automatic logic [31:0] fill_word(input logic [31:0] a);
    return {a[9:2], a[31:8]} ^ 32'h5ca1_ab1e;
  endfunction

  function automatic logic [31:0] ref_word(input logic [31:0] a);
    if (ref_mem.exists(a[31:2])) begin
      return ref_mem[a[31:2]];
    end
    return fill_word(a);  // never written
  endfunction

  task automatic check(input string name, input logic [63:0] expected,
                       input logic [63:0] actual);
    checks++;
    assert (expected === actual) else begin
      errors++;
      $display("ERROR %s: expected %0h, got %0h", name, expected, actual);
    end
  endtask

  task automatic report_timeout(input string what);
    errors++;
    timed_out = 1'b1;
    $display("timeout: %s", what);
  endtask

  task automatic wait_idle(input string name);
    int cycles;
    cycles = 0;
    while (busy && cycles < 10) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (busy) begin
      report_timeout({name, ": busy did not drop"});
    end
  endtask

  task automatic access(input string name, input logic write, input logic [31:0] addr,
                        input logic [31:0] data);
    logic [4:0]          idx;
    logic [tag_bits-1:0] tag;
    logic                hit;
    logic                evict;
    logic [31:0]         victim_base;
    logic [31:0]         expect_word;
    int                  cycles;
    int                  w;
    if (timed_out) begin
      return;
    end
    idx = addr[10:6];
    tag = addr[31:11];
    hit = ref_valid[idx] && (ref_tag[idx] == tag);
    evict = !hit && ref_valid[idx] && ref_dirty[idx];
    victim_base = {ref_tag[idx], idx, 6'b0};
    expect_word = ref_word(addr);
    mem_log.delete();
    req_en = 1'b1;
    req_write = write;
    req_addr = addr;
    req_data = data;
    @(posedge clk);
    #1;
    req_en = 1'b0;
    check({name, " busy after request"}, 64'(1), 64'(busy));
    cycles = 1;
    while (!resp_en && cycles < 100) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (!resp_en) begin
      report_timeout({name, ": no resp_en within 100 cycles"});
      return;
    end
    check({name, " busy at response"}, 64'(1), 64'(busy));
    if (hit) begin
      check({name, " hit latency"}, 64'(2), 64'(cycles));
      check({name, " memory requests"}, 64'(0), 64'(mem_log.size()));
    end else begin
      check({name, " memory requests"}, 64'(evict ? 2 : 1), 64'(mem_log.size()));
      if (evict && mem_log.size() == 2) begin
        check({name, " write-back addr"}, 64'({1'b1, ref_tag[idx], idx}), 64'(mem_log[0]));
        for (w = 0; w < 16; w++) begin
          check({name, " write-back word"}, 64'(ref_word(victim_base + 32'(w * 4))),
                64'(wb_line[w*32 +: 32]));
        end
      end
      if (mem_log.size() > 0) begin
        check({name, " refill addr"}, 64'({1'b0, tag, idx}),
              64'(mem_log[mem_log.size()-1]));
      end
    end
    if (!write) begin
      check({name, " read data"}, 64'(expect_word), 64'(resp_data));
    end
    ref_valid[idx] = 1'b1;
    ref_tag[idx] = tag;
    if (!hit) begin
      ref_dirty[idx] = 1'b0;  // fresh refill
    end
    if (write) begin
      ref_dirty[idx] = 1'b1;
      ref_mem[addr[31:2]] = data;
    end
    wait_idle(name);
  endtask

  task automatic do_flush(input string name);
    int cycles;
    int expect_wb;
    int wb_before;
    int i;
    if (timed_out) begin
      return;
    end
    expect_wb = 0;
    for (i = 0; i < num_lines; i++) begin
      if (ref_valid[i] && ref_dirty[i]) begin
        expect_wb++;
      end
    end
    wb_before = wb_count;
    flush = 1'b1;
    @(posedge clk);
    #1;
    flush = 1'b0;
    check({name, " busy after flush"}, 64'(1), 64'(busy));
    cycles = 0;
    while (!flush_done && cycles < 2000) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (!flush_done) begin
      report_timeout({name, ": no flush_done within 2000 cycles"});
      return;
    end
    check({name, " write-backs"}, 64'(expect_wb), 64'(wb_count - wb_before));
    ref_valid = '0;
    ref_dirty = '0;
    wait_idle(name);
  endtask

  initial begin
    logic [31:0] addr;
    logic [31:0] data;
    int          i;
    reset = 1'b1;
    req_en = 1'b0;
    req_write = 1'b0;
    req_addr = '0;
    req_data = '0;
    flush = 1'b0;
    checks = 0;
    errors = 0;
    timed_out = 1'b0;
    ref_valid = '0;
    ref_dirty = '0;
    repeat (5) @(posedge clk);
    #1;
    check("reset busy", 64'(0), 64'(busy));
    check("reset resp_en", 64'(0), 64'(resp_en));
    check("reset mem_req_en", 64'(0), 64'(mem_req_en));
    check("reset flush_done", 64'(0), 64'(flush_done));
    reset = 1'b0;
    @(posedge clk);
    #1;

    access("read_miss", 1'b0, 32'h0000_1048, '0);
    access("read_hit", 1'b0, 32'h0000_104c, '0);
    access("store_hit", 1'b1, 32'h0000_1048, 32'hdead_beef);
    access("store_readback", 1'b0, 32'h0000_1048, '0);
    access("store_neighbor_lo", 1'b0, 32'h0000_1044, '0);
    access("store_neighbor_hi", 1'b0, 32'h0000_104c, '0);
    // index 1 again under another tag
    access("dirty_evict", 1'b0, 32'h0000_1848, '0);
    access("clean_evict", 1'b0, 32'h0000_1048, '0);

    // stores to indices 0..7 with random tags and words
    for (i = 0; i < 8; i++) begin
      addr = ($random(seed) & 32'h0000_f83c) | 32'(i << 6);
      data = $random(seed);
      stored_addr.push_back(addr);
      access("random_store", 1'b1, addr, data);
      access("random_read", 1'b0, addr ^ 32'h4, '0);
    end

    do_flush("flush");
    foreach (stored_addr[k]) begin
      access("after_flush", 1'b0, stored_addr[k], '0);  // must miss
    end

    $display("checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
common/mem_msg_pkg.sv
common/cache_pkg.sv
common/cache_array_if.sv
cache/cache_tag_array.sv
cache/cache_data_array.sv
cache/cache_ctrl.sv
hw/cache_top.sv
dv/mem_model.sv
dv/cache_tb.sv

// File: Makefile
SOURCES := $(shell grep -v '^+' build.f)

.PHONY: all run clean

all: obj_dir/Vcache_tb

obj_dir/Vcache_tb: build.f $(SOURCES)
	verilator --binary --timing --assert --top-module cache_tb -f build.f

run: obj_dir/Vcache_tb
	@out="$$(./obj_dir/Vcache_tb)"; echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir
